//--- dv/mecobo_core_tb.sv
`default_nettype none

module mecobo_core_tb;

  localparam int FIFO_DEPTH     = 8;
  localparam int SAMPLE_DEPTH   = 16;
  localparam int NUM_PINS       = mecobo_pin_pkg::NUM_PINS;
  localparam int SETTLE_WINDOW  = 16;
  localparam int RELEASE_MARGIN = 24;
  localparam int PWM_PERIODS    = 4;
  localparam int MIN_SAMPLES    = 4;
  localparam logic [31:0] QUEUE_START = 32'd200;

  // cycle budget per test
  localparam int LEN_RESET     = 20;
  localparam int LEN_IMMEDIATE = 120;
  localparam int LEN_TIMED     = 260;
  localparam int LEN_PWM       = 160;
  localparam int LEN_CREDIT    = 350;
  localparam int LEN_SAMPLING  = 300;
  localparam int TIMEOUT_CYCLES = LEN_RESET + LEN_IMMEDIATE + LEN_TIMED + LEN_PWM +
                                  LEN_CREDIT + LEN_SAMPLING + 200;

  logic                     sys_clk;
  logic                     global_clock_reset;
  logic [7:0]               bus_addr;
  logic [15:0]              bus_wdata;
  logic                     bus_wr;
  logic                     bus_rd;
  logic [15:0]              bus_rdata;
  logic                     ready;
  mecobo_pin_pkg::pin_vec_t pins;

  logic [31:0] lfsr_state;
  int          cycle_count = 0;

  tb_clock_gen #(
    .PERIOD      (8),
    .RESET_CYCLES(2)
  ) clk0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset)
  );

  mecobo_core #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .SAMPLE_DEPTH(SAMPLE_DEPTH)
  ) dut0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset),
    .bus_addr          (bus_addr),
    .bus_wdata         (bus_wdata),
    .bus_wr            (bus_wr),
    .bus_rd            (bus_rd),
    .bus_rdata         (bus_rdata),
    .ready             (ready),
    .pins              (pins)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic next_random_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_bits(input int nbits);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < nbits; i++) v = {v[30:0], next_random_bit()};
    return v;
  endfunction

  task automatic check_pins(input string name, input mecobo_pin_pkg::pin_vec_t got,
                            input mecobo_pin_pkg::pin_vec_t expected);
    if (got !== expected)
      abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                          $time, name, got, expected));
  endtask

  task automatic check_word(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    if (got !== expected)
      abort_run($sformatf("MISMATCH time=%0t signal=%s got=%h expected=%h",
                          $time, name, got, expected));
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    if (got !== expected)
      abort_run($sformatf("MISMATCH time=%0t signal=%s got=%b expected=%b",
                          $time, name, got, expected));
  endtask

  // status layout: wptr 15:12, overflow bit 8, credits 7:0
  function automatic logic [15:0] expected_status(input int credits, input logic ovf,
                                                  input int wptr);
    return {4'(wptr), 3'b000, ovf, 8'(credits)};
  endfunction

  function automatic mecobo_cmd_pkg::cmd_word_t pin_command(
      input logic [3:0] index, input mecobo_pin_pkg::wave_t wave,
      input logic [11:0] period, input logic [11:0] high_time, input logic [31:0] start);
    mecobo_cmd_pkg::cmd_word_t c;
    c.pin.kind       = mecobo_cmd_pkg::KIND_PIN;
    c.pin.index      = index;
    c.pin.wave       = wave;
    c.pin.period     = period;
    c.pin.high_time  = high_time;
    c.pin.start_time = start;
    return c;
  endfunction

  function automatic mecobo_cmd_pkg::cmd_word_t control_command(
      input mecobo_cmd_pkg::cmd_kind_t kind, input logic [31:0] value);
    mecobo_cmd_pkg::cmd_word_t c;
    c.ctrl.kind  = kind;
    c.ctrl.pad   = '0;
    c.ctrl.value = value;
    return c;
  endfunction

  // one write, strobe held for a single edge
  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    @(posedge sys_clk);
    bus_addr  <= addr;
    bus_wdata <= data;
    bus_wr    <= 1'b1;
    @(posedge sys_clk);
    bus_wr <= 1'b0;
  endtask

  // word 3 last, that write commits
  task automatic send_cmd(input mecobo_cmd_pkg::cmd_word_t c);
    bus_write(mecobo_cmd_pkg::CMD_WORD0, c[15:0]);
    bus_write(mecobo_cmd_pkg::CMD_WORD1, c[31:16]);
    bus_write(mecobo_cmd_pkg::CMD_WORD2, c[47:32]);
    bus_write(mecobo_cmd_pkg::CMD_WORD3, c[63:48]);
  endtask

  // data taken at the falling edge after the registering edge
  task automatic read_word(input logic [7:0] addr, output logic [15:0] data);
    @(posedge sys_clk);
    bus_addr <= addr;
    bus_rd   <= 1'b1;
    @(posedge sys_clk);
    bus_rd <= 1'b0;
    @(negedge sys_clk);
    data = bus_rdata;
  endtask

  // poll pins until they match or the window runs out
  task automatic wait_pins(input mecobo_pin_pkg::pin_vec_t expected, input int window);
    int n;
    n = 0;
    @(negedge sys_clk);
    while (pins !== expected && n < window) begin
      @(negedge sys_clk);
      n++;
    end
    check_pins("pins", pins, expected);
  endtask

  task automatic reset_state();
    logic [15:0] status;
    @(negedge sys_clk);
    check_bit("ready", ready, 1'b1);
    check_pins("pins", pins, '0);
    read_word(mecobo_cmd_pkg::STATUS_ADDR, status);
    check_word("status", status, expected_status(FIFO_DEPTH, 1'b0, 0));
  endtask

  task automatic immediate_commands();
    logic [3:0]               chosen [3];
    mecobo_pin_pkg::pin_vec_t expected;
    expected = '0;
    for (int i = 0; i < 3; i++) begin
      chosen[i] = 4'(random_bits(4));
      expected[chosen[i]] = 1'b1;
      send_cmd(pin_command(chosen[i], mecobo_pin_pkg::WAVE_HIGH, 12'd0, 12'd0, 32'd0));
    end
    wait_pins(expected, SETTLE_WINDOW);
    // off brings every chosen pin back low
    for (int i = 0; i < 3; i++) begin
      send_cmd(pin_command(chosen[i], mecobo_pin_pkg::WAVE_OFF, 12'd0, 12'd0, 32'd0));
    end
    wait_pins('0, SETTLE_WINDOW);
  endtask

  task automatic timed_release();
    logic [3:0]  p;
    logic [31:0] t;
    p = 4'(random_bits(4));
    t = 32'd100 + random_bits(6);
    send_cmd(control_command(mecobo_cmd_pkg::KIND_CLEAR_TIME, 32'd0));
    send_cmd(pin_command(p, mecobo_pin_pkg::WAVE_HIGH, 12'd0, 12'd0, t));
    // time is near 7 here, pin command took 8 edges after the clear
    repeat (int'(t) - RELEASE_MARGIN - 8) @(posedge sys_clk);
    @(negedge sys_clk);
    check_bit("pin before start_time", pins[p], 1'b0);
    repeat (2 * RELEASE_MARGIN) @(posedge sys_clk);
    @(negedge sys_clk);
    check_bit("pin after start_time", pins[p], 1'b1);
    send_cmd(pin_command(p, mecobo_pin_pkg::WAVE_OFF, 12'd0, 12'd0, 32'd0));
    wait_pins('0, SETTLE_WINDOW);
  endtask

  task automatic pwm_duty();
    logic [3:0]               p;
    int                       per;
    int                       hi;
    int                       count;
    mecobo_pin_pkg::pin_vec_t expected;
    p   = 4'(random_bits(4));
    per = 6 + int'(random_bits(4));
    // duty strictly inside the period
    hi  = 1 + (int'(random_bits(4)) % (per - 1));
    send_cmd(pin_command(p, mecobo_pin_pkg::WAVE_PWM, 12'(per), 12'(hi), 32'd0));
    expected    = '0;
    expected[p] = 1'b1;
    wait_pins(expected, SETTLE_WINDOW);
    // any whole number of periods holds the same number of high cycles
    count = 0;
    repeat (PWM_PERIODS * per) begin
      @(negedge sys_clk);
      if (pins[p]) count++;
    end
    check_word("pwm high cycles", 16'(count), 16'(PWM_PERIODS * hi));
    send_cmd(pin_command(p, mecobo_pin_pkg::WAVE_OFF, 12'd0, 12'd0, 32'd0));
    wait_pins('0, SETTLE_WINDOW);
  endtask

  task automatic credit_flow();
    logic [15:0] status;
    int          polls;
    send_cmd(control_command(mecobo_cmd_pkg::KIND_CLEAR_TIME, 32'd0));
    // fill every slot, all held back by start time
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      send_cmd(pin_command(4'(i), mecobo_pin_pkg::WAVE_OFF, 12'd0, 12'd0, QUEUE_START));
    end
    @(negedge sys_clk);
    check_bit("ready", ready, 1'b0);
    // no credit left so this one is dropped
    send_cmd(pin_command(4'd0, mecobo_pin_pkg::WAVE_OFF, 12'd0, 12'd0, QUEUE_START));
    read_word(mecobo_cmd_pkg::STATUS_ADDR, status);
    check_word("status", status, expected_status(0, 1'b1, 0));
    polls = 0;
    while (!ready && polls < int'(QUEUE_START) * 2) begin
      @(negedge sys_clk);
      polls++;
    end
    if (!ready) abort_run("ready never rose after the queued commands fell due");
    // rest of the queue drains one per cycle
    polls = 0;
    read_word(mecobo_cmd_pkg::STATUS_ADDR, status);
    while (status[7:0] != 8'(FIFO_DEPTH) && polls < 2 * FIFO_DEPTH) begin
      read_word(mecobo_cmd_pkg::STATUS_ADDR, status);
      polls++;
    end
    check_word("status", status, expected_status(FIFO_DEPTH, 1'b1, 0));
    check_bit("ready", ready, 1'b1);
  endtask

  task automatic sampling();
    mecobo_pin_pkg::pin_vec_t pattern;
    logic [15:0]              status;
    logic [15:0]              sample;
    int                       interval;
    int                       written;
    int                       polls;
    pattern = 16'(random_bits(16));
    for (int i = 0; i < NUM_PINS; i++) begin
      if (pattern[i])
        send_cmd(pin_command(4'(i), mecobo_pin_pkg::WAVE_HIGH, 12'd0, 12'd0, 32'd0));
    end
    wait_pins(pattern, SETTLE_WINDOW);
    interval = 2 + int'(random_bits(3));
    send_cmd(control_command(mecobo_cmd_pkg::KIND_SET_INTERVAL, 32'(interval)));
    // poll the write pointer, far too fast for it to wrap between reads
    written = 0;
    polls   = 0;
    while (written < MIN_SAMPLES && polls < 40) begin
      read_word(mecobo_cmd_pkg::STATUS_ADDR, status);
      written = int'(status[15:12]);
      polls++;
    end
    if (written < MIN_SAMPLES) abort_run("sample write pointer did not advance");
    for (int i = 0; i < written; i++) begin
      read_word(mecobo_cmd_pkg::SAMPLE_BASE + 8'(i), sample);
      check_word($sformatf("sample[%0d]", i), sample, 16'(pattern));
    end
  endtask

  // hard stop if the tests overrun their budget
  always @(posedge sys_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout after %0d cycles, tests did not finish", cycle_count));
  end

  initial begin
    bus_addr   = 8'h00;
    bus_wdata  = 16'h0000;
    bus_wr     = 1'b0;
    bus_rd     = 1'b0;
    lfsr_state = 32'h8d1e_612b;
    wait (global_clock_reset === 1'b0);
    @(posedge sys_clk);
    reset_state();
    immediate_commands();
    timed_release();
    pwm_duty();
    credit_flow();
    sampling();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/tb_clock_gen.sv
`default_nettype none

// free running clock plus a synchronous reset pulse
module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic sys_clk,
  output logic global_clock_reset
);

  initial begin
    sys_clk = 1'b0;
    forever #(PERIOD / 2) sys_clk = ~sys_clk;
  end

  // reset held high for the first RESET_CYCLES rising edges
  initial begin
    global_clock_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge sys_clk);
    global_clock_reset <= 1'b0;
  end

endmodule

`default_nettype wire

//--- hw/cmd_fifo.sv
`default_nettype none

module cmd_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                      sys_clk,
  input  logic                      global_clock_reset,
  cmd_push_if.receiver              rx,
  output logic                      empty,
  output mecobo_cmd_pkg::cmd_word_t head,
  input  logic                      pop
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  mecobo_cmd_pkg::cmd_word_t mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;
  logic          full;

  assign empty = (count == '0);
  assign full  = (count == (PW+1)'(FIFO_DEPTH));
  // head is read straight out of the array
  assign head  = mem[rd_ptr];

  always_ff @(posedge sys_clk) begin
    if (rx.push) mem[wr_ptr] <= rx.data;
  end

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wr_ptr           <= '0;
      rd_ptr           <= '0;
      count            <= '0;
      rx.credit_return <= 1'b0;
    end else begin
      // pointers wrap at depth, not at a power of two
      if (rx.push) wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({rx.push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // freed slot goes back to the host one cycle after the pop
      rx.credit_return <= pop;
    end
  end

  // host credit loop keeps the FIFO from overfilling
  a_no_push_full: assert property (@(posedge rx.sys_clk) disable iff (global_clock_reset)
    rx.push |-> !full);
  // scheduler only pops a present head
  a_no_pop_empty: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    pop |-> !empty);

endmodule

`default_nettype wire

//--- hw/cmd_scheduler.sv
`default_nettype none

module cmd_scheduler (
  input  logic                      sys_clk,
  input  logic                      global_clock_reset,
  input  logic                      empty,
  input  mecobo_cmd_pkg::cmd_word_t head,
  output logic                      pop,
  cmd_bcast_if.source               bcast
);

  logic [31:0] global_time;
  logic        is_ctrl;
  logic        due;
  logic        clear_now;

  // control kinds go out without waiting
  assign is_ctrl = (head.ctrl.kind != mecobo_cmd_pkg::KIND_PIN);

  // compare against next cycle's time so the broadcast lands when time equals start
  assign due = ({1'b0, head.pin.start_time} <= {1'b0, global_time} + 33'd1);

  // only the head is looked at, later entries wait behind it
  assign pop = !empty && (is_ctrl || due);

  assign clear_now = pop && (head.ctrl.kind == mecobo_cmd_pkg::KIND_CLEAR_TIME);

  // global time, zeroed by a clear-time command
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      global_time <= 32'd0;
    end else if (clear_now) begin
      global_time <= 32'd0;
    end else begin
      global_time <= global_time + 32'd1;
    end
  end

  // broadcast valid flag
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      bcast.valid <= 1'b0;
    end else begin
      bcast.valid <= pop;
    end
  end

  // broadcast payload, captured with the pop
  always_ff @(posedge sys_clk) begin
    if (pop) bcast.data <= head;
  end

  assign bcast.cur_time = global_time;

endmodule

`default_nettype wire

//--- hw/host_bus_port.sv
`default_nettype none

module host_bus_port #(
  parameter int FIFO_DEPTH   = 8,
  parameter int SAMPLE_DEPTH = 16
) (
  input  logic                     sys_clk,
  input  logic                     global_clock_reset,
  input  logic [7:0]               bus_addr,
  input  logic [15:0]              bus_wdata,
  input  logic                     bus_wr,
  input  logic                     bus_rd,
  output logic [15:0]              bus_rdata,
  output logic                     ready,
  cmd_push_if.sender               tx,
  input  mecobo_pin_pkg::pin_vec_t sample_rdata,
  output logic [$clog2(SAMPLE_DEPTH)-1:0] sample_raddr,
  input  logic [$clog2(SAMPLE_DEPTH)-1:0] sample_wptr
);

  localparam int AW = $clog2(SAMPLE_DEPTH);

  logic [15:0] word_q [3];
  logic [7:0]  credits;
  logic        overflow;
  logic        commit;
  logic        in_sample;
  logic [15:0] status;

  // write to word 3 tries to commit
  assign commit = bus_wr && (bus_addr == mecobo_cmd_pkg::CMD_WORD3);

  // push goes out on the same edge as the word 3 write
  assign tx.push = commit && (credits != 8'd0);
  assign tx.data = {bus_wdata, word_q[2], word_q[1], word_q[0]};
  assign ready   = (credits != 8'd0);

  // lower three words held until commit
  always_ff @(posedge sys_clk) begin
    if (bus_wr && bus_addr == mecobo_cmd_pkg::CMD_WORD0) word_q[0] <= bus_wdata;
    if (bus_wr && bus_addr == mecobo_cmd_pkg::CMD_WORD1) word_q[1] <= bus_wdata;
    if (bus_wr && bus_addr == mecobo_cmd_pkg::CMD_WORD2) word_q[2] <= bus_wdata;
  end

  // credit counter and sticky overflow
  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      credits  <= 8'(FIFO_DEPTH);
      overflow <= 1'b0;
    end else begin
      case ({tx.push, tx.credit_return})
        2'b10:   credits <= credits - 8'd1;
        2'b01:   credits <= credits + 8'd1;
        default: credits <= credits;
      endcase
      // commit with nothing left to spend
      if (commit && credits == 8'd0) overflow <= 1'b1;
    end
  end

  // sample window decode
  assign in_sample    = (bus_addr >= mecobo_cmd_pkg::SAMPLE_BASE) &&
                        (bus_addr < mecobo_cmd_pkg::SAMPLE_BASE + 8'(SAMPLE_DEPTH));
  assign sample_raddr = AW'(bus_addr - mecobo_cmd_pkg::SAMPLE_BASE);

  always_comb begin
    status = '0;
    status[7:0] = credits;
    status[mecobo_cmd_pkg::STATUS_OVF_BIT] = overflow;
    status[mecobo_cmd_pkg::STATUS_WPTR_LSB +: 4] = 4'(sample_wptr);
  end

  // read data one cycle after bus_rd, unmapped reads give 0
  always_ff @(posedge sys_clk) begin
    if (bus_rd) begin
      if (bus_addr == mecobo_cmd_pkg::STATUS_ADDR) bus_rdata <= status;
      else if (in_sample) bus_rdata <= sample_rdata;
      else bus_rdata <= 16'h0000;
    end
  end

  // credits only come back for slots that were pushed
  a_credit_bound: assert property (@(posedge tx.sys_clk) disable iff (global_clock_reset)
    (tx.credit_return |-> credits != 8'(FIFO_DEPTH)) and (credits <= 8'(FIFO_DEPTH)));

endmodule

`default_nettype wire

//--- hw/mecobo_cmd_pkg.sv
`default_nettype none

package mecobo_cmd_pkg;

  // top two bits of every command word
  typedef enum logic [1:0] {
    KIND_PIN          = 2'd0,
    KIND_SET_INTERVAL = 2'd1,
    KIND_CLEAR_TIME   = 2'd2
  } cmd_kind_t;

  // pin command, released when start_time is reached
  typedef struct packed {
    cmd_kind_t                kind;
    logic [3:0]               index;
    mecobo_pin_pkg::wave_t    wave;
    logic [11:0]              period;
    logic [11:0]              high_time;
    logic [31:0]              start_time;
  } pin_cmd_t;

  // control command, acted on as soon as it is at the head
  typedef struct packed {
    cmd_kind_t   kind;
    logic [29:0] pad;
    logic [31:0] value;
  } ctrl_cmd_t;

  // same 64 bits, two views, kind lines up in both
  typedef union packed {
    pin_cmd_t  pin;
    ctrl_cmd_t ctrl;
  } cmd_word_t;

  // host bus address map
  localparam logic [7:0] CMD_WORD0   = 8'h00;
  localparam logic [7:0] CMD_WORD1   = 8'h01;
  localparam logic [7:0] CMD_WORD2   = 8'h02;
  // write here commits the whole command
  localparam logic [7:0] CMD_WORD3   = 8'h03;
  localparam logic [7:0] STATUS_ADDR = 8'h10;
  localparam logic [7:0] SAMPLE_BASE = 8'h20;

  // status word layout
  localparam int STATUS_OVF_BIT  = 8;
  localparam int STATUS_WPTR_LSB = 12;

endpackage

`default_nettype wire

//--- hw/mecobo_core.sv
`default_nettype none

module mecobo_core #(
  parameter int FIFO_DEPTH   = 8,
  parameter int SAMPLE_DEPTH = 16
) (
  input  logic                     sys_clk,
  input  logic                     global_clock_reset,
  input  logic [7:0]               bus_addr,
  input  logic [15:0]              bus_wdata,
  input  logic                     bus_wr,
  input  logic                     bus_rd,
  output logic [15:0]              bus_rdata,
  output logic                     ready,
  output mecobo_pin_pkg::pin_vec_t pins
);

  localparam int AW = $clog2(SAMPLE_DEPTH);

  mecobo_cmd_pkg::cmd_word_t head;
  mecobo_pin_pkg::pin_vec_t  sample_rdata;
  logic [AW-1:0] sample_raddr;
  logic [AW-1:0] sample_wptr;
  logic          empty;
  logic          pop;

  cmd_push_if  push_if (.sys_clk(sys_clk));
  cmd_bcast_if bcast_if ();

  // host side, credit master
  host_bus_port #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .SAMPLE_DEPTH(SAMPLE_DEPTH)
  ) host0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset),
    .bus_addr          (bus_addr),
    .bus_wdata         (bus_wdata),
    .bus_wr            (bus_wr),
    .bus_rd            (bus_rd),
    .bus_rdata         (bus_rdata),
    .ready             (ready),
    .tx                (push_if.sender),
    .sample_rdata      (sample_rdata),
    .sample_raddr      (sample_raddr),
    .sample_wptr       (sample_wptr)
  );

  cmd_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) fifo0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset),
    .rx                (push_if.receiver),
    .empty             (empty),
    .head              (head),
    .pop               (pop)
  );

  cmd_scheduler sched0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset),
    .empty             (empty),
    .head              (head),
    .pop               (pop),
    .bcast             (bcast_if.source)
  );

  // one controller per pin, each matches its own index
  for (genvar i = 0; i < mecobo_pin_pkg::NUM_PINS; i++) begin : g_pin
    pin_control #(
      .POSITION(i)
    ) pc (
      .sys_clk           (sys_clk),
      .global_clock_reset(global_clock_reset),
      .bcast             (bcast_if.listener),
      .pin               (pins[i])
    );
  end

  sample_buffer #(
    .SAMPLE_DEPTH(SAMPLE_DEPTH)
  ) samp0 (
    .sys_clk           (sys_clk),
    .global_clock_reset(global_clock_reset),
    .bcast             (bcast_if.listener),
    .pins              (pins),
    .sample_raddr      (sample_raddr),
    .sample_rdata      (sample_rdata),
    .sample_wptr       (sample_wptr)
  );

endmodule

`default_nettype wire

//--- hw/mecobo_ifs.sv
`default_nettype none

// credit push channel, host port to command FIFO
interface cmd_push_if (
  input logic sys_clk
);

  logic                      push;
  mecobo_cmd_pkg::cmd_word_t data;
  // one pulse per freed FIFO slot
  logic                      credit_return;

  modport sender (
    input  sys_clk,
    output push,
    output data,
    input  credit_return
  );

  modport receiver (
    input  sys_clk,
    input  push,
    input  data,
    output credit_return
  );

endinterface

// command broadcast from the scheduler, no back-pressure
interface cmd_bcast_if;

  logic                      valid;
  mecobo_cmd_pkg::cmd_word_t data;
  // scheduler global time in the broadcast cycle
  logic [31:0]               cur_time;

  modport source (
    output valid,
    output data,
    output cur_time
  );

  modport listener (
    input valid,
    input data,
    input cur_time
  );

endinterface

`default_nettype wire

//--- hw/mecobo_pin_pkg.sv
`default_nettype none

package mecobo_pin_pkg;

  // number of driven pins on the header
  localparam int NUM_PINS = 16;

  // pin waveform codes
  // off drives low, high drives high, pwm runs the phase counter
  typedef enum logic [1:0] {
    WAVE_OFF  = 2'd0,
    WAVE_HIGH = 2'd1,
    WAVE_PWM  = 2'd2
  } wave_t;

  // one bit per pin, bit i is pin i
  typedef logic [NUM_PINS-1:0] pin_vec_t;

endpackage

`default_nettype wire

//--- hw/pin_control.sv
`default_nettype none

module pin_control #(
  parameter int POSITION = 0
) (
  input  logic          sys_clk,
  input  logic          global_clock_reset,
  cmd_bcast_if.listener bcast,
  output logic          pin
);

  mecobo_pin_pkg::wave_t wave;
  logic [11:0] period;
  logic [11:0] high_time;
  logic [11:0] phase;
  logic        accept;

  // pin command addressed to this position
  assign accept = bcast.valid &&
                  (bcast.data.pin.kind == mecobo_cmd_pkg::KIND_PIN) &&
                  (bcast.data.pin.index == 4'(POSITION));

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      wave      <= mecobo_pin_pkg::WAVE_OFF;
      period    <= 12'd0;
      high_time <= 12'd0;
      phase     <= 12'd0;
    end else if (accept) begin
      wave      <= bcast.data.pin.wave;
      period    <= bcast.data.pin.period;
      high_time <= bcast.data.pin.high_time;
      // new command starts a fresh period
      phase     <= 12'd0;
    end else if (wave == mecobo_pin_pkg::WAVE_PWM) begin
      // wraps at period minus 1
      // zero period holds phase at 0
      if (period == 12'd0 || phase >= period - 12'd1) phase <= 12'd0;
      else phase <= phase + 12'd1;
    end
  end

  // output follows the stored state, one cycle after the broadcast
  always_comb begin
    case (wave)
      mecobo_pin_pkg::WAVE_HIGH: pin = 1'b1;
      // high for the first high_time cycles of each period
      mecobo_pin_pkg::WAVE_PWM:  pin = (phase < high_time);
      default:                   pin = 1'b0;
    endcase
  end

  // host must not send a duty above the period
  a_duty_in_range: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    (wave == mecobo_pin_pkg::WAVE_PWM) |-> (high_time <= period));

  // scheduler never releases a pin command before its start time
  a_released_when_due: assert property (@(posedge sys_clk) disable iff (global_clock_reset)
    accept |-> (bcast.cur_time >= bcast.data.pin.start_time));

endmodule

`default_nettype wire

//--- hw/sample_buffer.sv
`default_nettype none

module sample_buffer #(
  parameter int SAMPLE_DEPTH = 16
) (
  input  logic                     sys_clk,
  input  logic                     global_clock_reset,
  cmd_bcast_if.listener            bcast,
  input  mecobo_pin_pkg::pin_vec_t pins,
  input  logic [$clog2(SAMPLE_DEPTH)-1:0] sample_raddr,
  output mecobo_pin_pkg::pin_vec_t sample_rdata,
  output logic [$clog2(SAMPLE_DEPTH)-1:0] sample_wptr
);

  localparam int AW = $clog2(SAMPLE_DEPTH);

  mecobo_pin_pkg::pin_vec_t mem [SAMPLE_DEPTH];
  logic [31:0] interval;
  logic [31:0] tick;
  logic        set_interval;
  logic        take;

  assign set_interval = bcast.valid &&
                        (bcast.data.ctrl.kind == mecobo_cmd_pkg::KIND_SET_INTERVAL);
  // snapshot on the last tick of each interval, stopped while interval is 0
  assign take = !set_interval && (interval != 32'd0) && (tick == interval - 32'd1);

  always_ff @(posedge sys_clk) begin
    if (global_clock_reset) begin
      interval    <= 32'd0;
      tick        <= 32'd0;
      sample_wptr <= '0;
    end else if (set_interval) begin
      interval <= bcast.data.ctrl.value;
      tick     <= 32'd0;
    end else if (take) begin
      tick        <= 32'd0;
      sample_wptr <= (sample_wptr == AW'(SAMPLE_DEPTH - 1)) ? '0 : sample_wptr + 1'b1;
    end else if (interval != 32'd0) begin
      tick <= tick + 32'd1;
    end
  end

  // circular store of pin snapshots
  always_ff @(posedge sys_clk) begin
    if (take) mem[sample_wptr] <= pins;
  end

  // host port registers this
  assign sample_rdata = mem[sample_raddr];

endmodule

`default_nettype wire

//--- mecobo_core.f
hw/mecobo_pin_pkg.sv
hw/mecobo_cmd_pkg.sv
hw/mecobo_ifs.sv
hw/host_bus_port.sv
hw/cmd_fifo.sv
hw/cmd_scheduler.sv
hw/pin_control.sv
hw/sample_buffer.sv
hw/mecobo_core.sv
dv/tb_clock_gen.sv
dv/mecobo_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f mecobo_core.f \
  --top-module mecobo_core_tb -Mdir obj_dir

output="$(./obj_dir/Vmecobo_core_tb || true)"
echo "${output}"

if grep -q "ALL CHECKS PASSED" <<< "${output}"; then
  exit 0
else
  exit 1
fi
